// ==== sniff_consts.svh ====
// packet sniffer constants
// word widths, input FIFO sizing and IPv4 header field values

`ifndef SNIFF_CONSTS_SVH
`define SNIFF_CONSTS_SVH

////////////////////////////////////////
// stream word widths
////////////////////////////////////////
`define SNIFF_DATA_W     64
`define SNIFF_CTRL_W     8

////////////////////////////////////////
// input FIFO
////////////////////////////////////////
// depth is a power of two so the pointers wrap on their own
`define SNIFF_FIFO_AW    3
`define SNIFF_FIFO_DEPTH (1 << `SNIFF_FIFO_AW)
// leaves two words of slack for the source
`define SNIFF_FIFO_NEAR  6

////////////////////////////////////////
// counters and header fields
////////////////////////////////////////
`define SNIFF_CNT_W      32
`define SNIFF_IP_W       32
`define SNIFF_PORT_W     16
`define SNIFF_IPV4_VER   4'd4

`endif

// ==== sniff_pkg.sv ====
// packet sniffer types
// protocol numbers, parser states and the captured TCP flow

`include "sniff_consts.svh"

package sniff_pkg;

   ////////////////////////////////////////
   // IP protocol field
   ////////////////////////////////////////
   // only the protocols that get their own counter
   typedef enum logic [7:0] {
      icmp = 8'd1,
      tcp  = 8'd6,
      udp  = 8'd17,
      sctp = 8'd132
   } ip_proto_t;

   ////////////////////////////////////////
   // parser FSM
   ////////////////////////////////////////
   typedef enum logic [2:0] {
      skip_hdr,     // module headers, waiting for word 1
      word2_ver,    // IP version check
      word3_proto,  // protocol and total length
      word4_ip,     // source IP, upper destination IP
      word5_port,   // ports and upper sequence half
      payload       // rest of packet until control goes nonzero
   } parse_state_t;

   ////////////////////////////////////////
   // TCP flow identity, 128 bits
   ////////////////////////////////////////
   typedef struct packed {
      logic [`SNIFF_IP_W-1:0]   src_ip;
      logic [`SNIFF_IP_W-1:0]   dst_ip;
      logic [`SNIFF_PORT_W-1:0] src_port;
      logic [`SNIFF_PORT_W-1:0] dst_port;
      logic [`SNIFF_PORT_W-1:0] length;
      logic [`SNIFF_PORT_W-1:0] seq_hi;
   } tcp_flow_t;

endpackage

// ==== parse_event_if.sv ====
// parse event bundle
// one-cycle pulses from the header parser to the statistics block

`timescale 1ns/10ps

interface parse_event_if;

   // first zero-control word of a packet accepted
   logic                 pkt_start;
   // word 3 of an IPv4 packet accepted, proto is valid
   logic                 proto_valid;
   sniff_pkg::ip_proto_t proto;
   // word 5 of a TCP packet accepted
   logic                 flow_done;

   modport parser (
      output pkt_start,
      output proto_valid,
      output proto,
      output flow_done
   );

   modport stats (
      input pkt_start,
      input proto_valid,
      input proto,
      input flow_done
   );

endinterface

// ==== pkt_fifo.sv ====
// input FIFO for data and control words
// fall-through head, fill count and nearly-full flag

`timescale 1ns/10ps
`include "sniff_consts.svh"

module pkt_fifo (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`SNIFF_DATA_W-1:0] din_data,
   input  logic [`SNIFF_CTRL_W-1:0] din_ctrl,
   input  logic                     wr_en,
   input  logic                     rd_en,
   output logic [`SNIFF_DATA_W-1:0] dout_data,
   output logic [`SNIFF_CTRL_W-1:0] dout_ctrl,
   output logic                     empty,
   output logic                     nearly_full
);

   logic [`SNIFF_DATA_W-1:0]  data_mem [`SNIFF_FIFO_DEPTH];
   logic [`SNIFF_CTRL_W-1:0]  ctrl_mem [`SNIFF_FIFO_DEPTH];
   logic [`SNIFF_FIFO_AW-1:0] wr_ptr;
   logic [`SNIFF_FIFO_AW-1:0] rd_ptr;
   logic [`SNIFF_FIFO_AW:0]   fill;
   logic                      full;
   logic                      do_wr;
   logic                      do_rd;

   assign full        = (fill == (`SNIFF_FIFO_AW+1)'(`SNIFF_FIFO_DEPTH));
   assign empty       = (fill == '0);
   assign nearly_full = (fill >= (`SNIFF_FIFO_AW+1)'(`SNIFF_FIFO_NEAR));

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // head word shows without read latency
   assign dout_data = data_mem[rd_ptr];
   assign dout_ctrl = ctrl_mem[rd_ptr];

   ////////////////////////////////////////
   // storage
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (do_wr) begin
         data_mem[wr_ptr] <= din_data;
         ctrl_mem[wr_ptr] <= din_ctrl;
      end
   end

   ////////////////////////////////////////
   // pointers and fill level
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous read and write keeps the level
         if (do_wr && !do_rd) begin
            fill <= fill + 1'b1;
         end else if (do_rd && !do_wr) begin
            fill <= fill - 1'b1;
         end
      end
   end

   // source must honour in_rdy, sink must check empty
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !full);

   a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      rd_en |-> !empty);

endmodule

// ==== hdr_parser.sv ====
// packet header parser
// passes the stream through, classifies IPv4 protocols, captures TCP flows

`timescale 1ns/10ps
`include "sniff_consts.svh"

module hdr_parser (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`SNIFF_DATA_W-1:0] head_data,
   input  logic [`SNIFF_CTRL_W-1:0] head_ctrl,
   input  logic                     fifo_empty,
   output logic                     fifo_rd,
   output logic [`SNIFF_DATA_W-1:0] out_data,
   output logic [`SNIFF_CTRL_W-1:0] out_ctrl,
   output logic                     out_wr,
   input  logic                     out_rdy,
   parse_event_if.parser            ev,
   output sniff_pkg::tcp_flow_t     flow,
   output logic                     flow_valid
);

   sniff_pkg::parse_state_t   state;
   sniff_pkg::parse_state_t   state_next;
   sniff_pkg::ip_proto_t      head_proto;
   logic                      accept;
   logic                      take_start;
   logic                      take_proto;
   logic                      take_word4;
   logic                      take_word5;

   // fields seen before word 5, held until the flow is complete
   logic [`SNIFF_PORT_W-1:0]  len_q;
   logic [`SNIFF_IP_W-1:0]    src_ip_q;
   logic [`SNIFF_PORT_W-1:0]  dst_hi_q;

   ////////////////////////////////////////
   // pass-through
   ////////////////////////////////////////
   assign accept   = !fifo_empty && out_rdy;
   assign out_wr   = accept;
   assign fifo_rd  = accept;
   assign out_data = head_data;
   assign out_ctrl = head_ctrl;

   assign head_proto = sniff_pkg::ip_proto_t'(head_data[7:0]);

   assign take_start = accept && (state == sniff_pkg::skip_hdr) && (head_ctrl == '0);
   assign take_proto = accept && (state == sniff_pkg::word3_proto);
   assign take_word4 = accept && (state == sniff_pkg::word4_ip);
   assign take_word5 = accept && (state == sniff_pkg::word5_port);

   // events for the statistics block
   assign ev.pkt_start   = take_start;
   assign ev.proto_valid = take_proto;
   assign ev.proto       = head_proto;
   assign ev.flow_done   = take_word5;

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////
   always_comb begin
      state_next = state;
      if (accept) begin
         case (state)
            sniff_pkg::skip_hdr: begin
               if (head_ctrl == '0) begin
                  state_next = sniff_pkg::word2_ver;
               end
            end
            sniff_pkg::word2_ver: begin
               if (head_data[15:12] == `SNIFF_IPV4_VER) begin
                  state_next = sniff_pkg::word3_proto;
               end else begin
                  state_next = sniff_pkg::payload;
               end
            end
            sniff_pkg::word3_proto: begin
               // only TCP carries on into the flow words
               if (head_proto == sniff_pkg::tcp) begin
                  state_next = sniff_pkg::word4_ip;
               end else begin
                  state_next = sniff_pkg::payload;
               end
            end
            sniff_pkg::word4_ip: begin
               state_next = sniff_pkg::word5_port;
            end
            sniff_pkg::word5_port: begin
               state_next = sniff_pkg::payload;
            end
            sniff_pkg::payload: begin
               // nonzero control marks the last word
               if (head_ctrl != '0) begin
                  state_next = sniff_pkg::skip_hdr;
               end
            end
            default: begin
               state_next = sniff_pkg::skip_hdr;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sniff_pkg::skip_hdr;
      end else begin
         state <= state_next;
      end
   end

   ////////////////////////////////////////
   // flow capture
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (take_proto) begin
         len_q <= head_data[63:48];
      end
      if (take_word4) begin
         src_ip_q <= head_data[47:16];
         dst_hi_q <= head_data[15:0];
      end
   end

   // whole flow changes at once on word 5
   always_ff @(posedge clk) begin
      if (reset) begin
         flow       <= '0;
         flow_valid <= 1'b0;
      end else begin
         flow_valid <= take_word5;
         if (take_word5) begin
            flow.src_ip   <= src_ip_q;
            flow.dst_ip   <= {dst_hi_q, head_data[63:48]};
            flow.src_port <= head_data[47:32];
            flow.dst_port <= head_data[31:16];
            flow.length   <= len_q;
            flow.seq_hi   <= head_data[15:0];
         end
      end
   end

   a_evt_excl: assert property (@(posedge clk) disable iff (reset)
      !(ev.proto_valid && ev.pkt_start));

endmodule

// ==== proto_stats.sv ====
// per-protocol packet statistics
// counts packets and IPv4 protocols from parser events

`timescale 1ns/10ps
`include "sniff_consts.svh"

module proto_stats (
   input  logic                    clk,
   input  logic                    reset,
   parse_event_if.stats            ev,
   output logic [`SNIFF_CNT_W-1:0] pkt_count,
   output logic [`SNIFF_CNT_W-1:0] tcp_count,
   output logic [`SNIFF_CNT_W-1:0] udp_count,
   output logic [`SNIFF_CNT_W-1:0] icmp_count,
   output logic [`SNIFF_CNT_W-1:0] sctp_count
);

   ////////////////////////////////////////
   // counters
   ////////////////////////////////////////
   // all counters wrap at full width
   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_count  <= '0;
         tcp_count  <= '0;
         udp_count  <= '0;
         icmp_count <= '0;
         sctp_count <= '0;
      end else begin
         if (ev.pkt_start) begin
            pkt_count <= pkt_count + 1'b1;
         end
         if (ev.proto_valid) begin
            case (ev.proto)
               sniff_pkg::tcp: begin
                  tcp_count <= tcp_count + 1'b1;
               end
               sniff_pkg::udp: begin
                  udp_count <= udp_count + 1'b1;
               end
               sniff_pkg::icmp: begin
                  icmp_count <= icmp_count + 1'b1;
               end
               sniff_pkg::sctp: begin
                  sctp_count <= sctp_count + 1'b1;
               end
               default: begin
                  // unknown protocol, no counter
               end
            endcase
         end
      end
   end

   // each event belongs to a different packet word
   a_flow_alone: assert property (@(posedge clk) disable iff (reset)
      ev.flow_done |-> !ev.pkt_start && !ev.proto_valid);

endmodule

// ==== pkt_sniffer.sv ====
// packet sniffer top level
// input FIFO, header parser and protocol statistics on plain ports

`timescale 1ns/10ps
`include "sniff_consts.svh"

module pkt_sniffer (
   input  logic                     clk,
   input  logic                     reset,
   // input stream
   input  logic [`SNIFF_DATA_W-1:0] in_data,
   input  logic [`SNIFF_CTRL_W-1:0] in_ctrl,
   input  logic                     in_wr,
   output logic                     in_rdy,
   // output stream
   output logic [`SNIFF_DATA_W-1:0] out_data,
   output logic [`SNIFF_CTRL_W-1:0] out_ctrl,
   output logic                     out_wr,
   input  logic                     out_rdy,
   // statistics
   output logic [`SNIFF_CNT_W-1:0]  pkt_count,
   output logic [`SNIFF_CNT_W-1:0]  tcp_count,
   output logic [`SNIFF_CNT_W-1:0]  udp_count,
   output logic [`SNIFF_CNT_W-1:0]  icmp_count,
   output logic [`SNIFF_CNT_W-1:0]  sctp_count,
   // last TCP flow
   output logic [`SNIFF_IP_W-1:0]   flow_src_ip,
   output logic [`SNIFF_IP_W-1:0]   flow_dst_ip,
   output logic [`SNIFF_PORT_W-1:0] flow_src_port,
   output logic [`SNIFF_PORT_W-1:0] flow_dst_port,
   output logic [`SNIFF_PORT_W-1:0] flow_length,
   output logic [`SNIFF_PORT_W-1:0] flow_seq_hi,
   output logic                     flow_valid
);

   logic [`SNIFF_DATA_W-1:0] head_data;
   logic [`SNIFF_CTRL_W-1:0] head_ctrl;
   logic                     fifo_empty;
   logic                     fifo_rd;
   logic                     fifo_nearly_full;
   sniff_pkg::tcp_flow_t     flow;

   parse_event_if ev_if ();

   assign in_rdy = !fifo_nearly_full;

   pkt_fifo fifo0 (
      .clk         (clk),
      .reset       (reset),
      .din_data    (in_data),
      .din_ctrl    (in_ctrl),
      .wr_en       (in_wr),
      .rd_en       (fifo_rd),
      .dout_data   (head_data),
      .dout_ctrl   (head_ctrl),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   hdr_parser parser0 (
      .clk        (clk),
      .reset      (reset),
      .head_data  (head_data),
      .head_ctrl  (head_ctrl),
      .fifo_empty (fifo_empty),
      .fifo_rd    (fifo_rd),
      .out_data   (out_data),
      .out_ctrl   (out_ctrl),
      .out_wr     (out_wr),
      .out_rdy    (out_rdy),
      .ev         (ev_if.parser),
      .flow       (flow),
      .flow_valid (flow_valid)
   );

   proto_stats stats0 (
      .clk        (clk),
      .reset      (reset),
      .ev         (ev_if.stats),
      .pkt_count  (pkt_count),
      .tcp_count  (tcp_count),
      .udp_count  (udp_count),
      .icmp_count (icmp_count),
      .sctp_count (sctp_count)
   );

   // flow struct onto plain ports
   assign flow_src_ip   = flow.src_ip;
   assign flow_dst_ip   = flow.dst_ip;
   assign flow_src_port = flow.src_port;
   assign flow_dst_port = flow.dst_port;
   assign flow_length   = flow.length;
   assign flow_seq_hi   = flow.seq_hi;

endmodule

// ==== tb_pkt_sniffer.sv ====
// testbench for the packet sniffer
// random packets through the DUT, checked against a reference model

`timescale 1ns/10ps
`include "sniff_consts.svh"

module tb_pkt_sniffer;

   localparam int NUM_PKTS    = 60;
   localparam int STALL_LIMIT = 200;
   localparam int DRAIN_LIMIT = 2000;

   logic                     clk;
   logic                     reset;
   logic [`SNIFF_DATA_W-1:0] in_data;
   logic [`SNIFF_CTRL_W-1:0] in_ctrl;
   logic                     in_wr;
   logic                     in_rdy;
   logic [`SNIFF_DATA_W-1:0] out_data;
   logic [`SNIFF_CTRL_W-1:0] out_ctrl;
   logic                     out_wr;
   logic                     out_rdy;
   logic [`SNIFF_CNT_W-1:0]  pkt_count;
   logic [`SNIFF_CNT_W-1:0]  tcp_count;
   logic [`SNIFF_CNT_W-1:0]  udp_count;
   logic [`SNIFF_CNT_W-1:0]  icmp_count;
   logic [`SNIFF_CNT_W-1:0]  sctp_count;
   logic [`SNIFF_IP_W-1:0]   flow_src_ip;
   logic [`SNIFF_IP_W-1:0]   flow_dst_ip;
   logic [`SNIFF_PORT_W-1:0] flow_src_port;
   logic [`SNIFF_PORT_W-1:0] flow_dst_port;
   logic [`SNIFF_PORT_W-1:0] flow_length;
   logic [`SNIFF_PORT_W-1:0] flow_seq_hi;
   logic                     flow_valid;

   // stimulus and reference model
   logic [`SNIFF_DATA_W-1:0] stim_data_q [$];
   logic [`SNIFF_CTRL_W-1:0] stim_ctrl_q [$];
   logic [`SNIFF_DATA_W-1:0] exp_data_q [$];
   logic [`SNIFF_CTRL_W-1:0] exp_ctrl_q [$];
   sniff_pkg::tcp_flow_t     exp_flow_q [$];
   logic [`SNIFF_CNT_W-1:0]  exp_pkt;
   logic [`SNIFF_CNT_W-1:0]  exp_tcp;
   logic [`SNIFF_CNT_W-1:0]  exp_udp;
   logic [`SNIFF_CNT_W-1:0]  exp_icmp;
   logic [`SNIFF_CNT_W-1:0]  exp_sctp;
   int                       flow_pulses;
   // words written into the DUT and not yet sent out
   int                       held;

   pkt_sniffer dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////
   // failure reporting and compares
   ////////////////////////////////////////
   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_data(input string name, input logic [`SNIFF_DATA_W-1:0] got,
                             input logic [`SNIFF_DATA_W-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERR %0d ns %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_ctrl(input string name, input logic [`SNIFF_CTRL_W-1:0] got,
                             input logic [`SNIFF_CTRL_W-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERR %0d ns %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input logic [`SNIFF_CNT_W-1:0] got,
                              input logic [`SNIFF_CNT_W-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERR %0d ns %s got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERR %0d ns %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_flow(input sniff_pkg::tcp_flow_t got, input sniff_pkg::tcp_flow_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERR %0d ns flow got %h expected %h", $time, got, exp));
   endtask

   ////////////////////////////////////////
   // packet generation and model
   ////////////////////////////////////////
   task automatic push_word(input logic [`SNIFF_DATA_W-1:0] d, input logic [`SNIFF_CTRL_W-1:0] c);
      stim_data_q.push_back(d);
      stim_ctrl_q.push_back(c);
      exp_data_q.push_back(d);
      exp_ctrl_q.push_back(c);
   endtask

   task automatic build_packets(input int n_pkts);
      int                       n_hdr;
      int                       n_body;
      int                       sel;
      logic                     is_ipv4;
      logic [7:0]               proto_val;
      logic [3:0]               ver;
      sniff_pkg::tcp_flow_t     fl;
      logic [`SNIFF_DATA_W-1:0] body [1:9];
      for (int p = 0; p < n_pkts; p++) begin
         n_hdr   = int'($urandom_range(0, 2));
         n_body  = int'($urandom_range(5, 9));
         is_ipv4 = ($urandom_range(0, 99) < 80);
         ver     = is_ipv4 ? 4'd4 : 4'($urandom_range(5, 15));
         sel     = int'($urandom_range(0, 4));
         case (sel)
            0: proto_val = 8'd1;
            1: proto_val = 8'd6;
            2: proto_val = 8'd17;
            3: proto_val = 8'd132;
            // GRE, counted nowhere
            default: proto_val = 8'd47;
         endcase
         fl.src_ip   = $urandom;
         fl.dst_ip   = $urandom;
         fl.src_port = 16'($urandom);
         fl.dst_port = 16'($urandom);
         fl.length   = 16'($urandom);
         fl.seq_hi   = 16'($urandom);
         for (int w = 1; w <= 9; w++) begin
            body[w] = {$urandom, $urandom};
         end
         // header fields at their places in words 2 to 5
         body[2][15:12] = ver;
         body[3][7:0]   = proto_val;
         body[3][63:48] = fl.length;
         body[4][47:16] = fl.src_ip;
         body[4][15:0]  = fl.dst_ip[31:16];
         body[5]        = {fl.dst_ip[15:0], fl.src_port, fl.dst_port, fl.seq_hi};
         for (int h = 0; h < n_hdr; h++) begin
            push_word({$urandom, $urandom}, 8'hff);
         end
         for (int w = 1; w <= n_body; w++) begin
            push_word(body[w], 8'h00);
         end
         push_word({$urandom, $urandom}, 8'($urandom_range(1, 255)));
         exp_pkt = exp_pkt + 1'b1;
         if (is_ipv4) begin
            case (sel)
               0: exp_icmp = exp_icmp + 1'b1;
               1: exp_tcp  = exp_tcp + 1'b1;
               2: exp_udp  = exp_udp + 1'b1;
               3: exp_sctp = exp_sctp + 1'b1;
               default: ;
            endcase
            if (sel == 1) exp_flow_q.push_back(fl);
         end
      end
   endtask

   ////////////////////////////////////////
   // output monitor, sampled mid-cycle
   ////////////////////////////////////////
   always @(negedge clk) begin : monitor
      sniff_pkg::tcp_flow_t got_flow;
      if (!reset) begin
         if (out_wr) begin
            check_flag("out_rdy", out_rdy, 1'b1);
            if (exp_data_q.size() == 0)
               stop_with_failure("DUT sent a word that was never written");
            check_data("out_data", out_data, exp_data_q.pop_front());
            check_ctrl("out_ctrl", out_ctrl, exp_ctrl_q.pop_front());
         end
         // ready drops once the held words reach the nearly-full level
         check_flag("in_rdy", in_rdy, (held < `SNIFF_FIFO_NEAR));
         // transfers that happen at the coming rising edge
         held = held + (in_wr ? 1 : 0) - (out_wr ? 1 : 0);
         if (flow_valid) begin
            if (exp_flow_q.size() == 0)
               stop_with_failure("flow_valid pulsed with no TCP packet expected");
            got_flow.src_ip   = flow_src_ip;
            got_flow.dst_ip   = flow_dst_ip;
            got_flow.src_port = flow_src_port;
            got_flow.dst_port = flow_dst_port;
            got_flow.length   = flow_length;
            got_flow.seq_hi   = flow_seq_hi;
            check_flow(got_flow, exp_flow_q.pop_front());
            flow_pulses++;
         end
      end
   end

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin : main
      int stall;
      int wait_cnt;
      void'($urandom(32'hc66f4c3c));
      reset = 1'b1;
      in_data = '0;
      in_ctrl = '0;
      in_wr = 1'b0;
      // sink ready, so an empty FIFO alone keeps out_wr low
      out_rdy = 1'b1;
      exp_pkt = '0;
      exp_tcp = '0;
      exp_udp = '0;
      exp_icmp = '0;
      exp_sctp = '0;
      flow_pulses = 0;
      held = 0;
      build_packets(NUM_PKTS);
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      // state right after reset
      check_flag("out_wr", out_wr, 1'b0);
      check_flag("flow_valid", flow_valid, 1'b0);
      check_count("pkt_count", pkt_count, '0);
      check_count("tcp_count", tcp_count, '0);
      check_count("udp_count", udp_count, '0);
      check_count("icmp_count", icmp_count, '0);
      check_count("sctp_count", sctp_count, '0);
      stall = 0;
      while (stim_data_q.size() > 0) begin
         @(posedge clk);
         #1;
         out_rdy = ($urandom_range(0, 3) != 0);
         if (in_rdy && ($urandom_range(0, 4) != 0)) begin
            in_data = stim_data_q.pop_front();
            in_ctrl = stim_ctrl_q.pop_front();
            in_wr   = 1'b1;
            stall   = 0;
         end else begin
            in_wr = 1'b0;
            stall++;
            if (stall > STALL_LIMIT) stop_with_failure("timeout waiting for in_rdy");
         end
      end
      @(posedge clk);
      #1;
      in_wr = 1'b0;
      wait_cnt = 0;
      while (exp_data_q.size() > 0) begin
         @(posedge clk);
         #1;
         out_rdy = ($urandom_range(0, 3) != 0);
         wait_cnt++;
         if (wait_cnt > DRAIN_LIMIT) stop_with_failure("timeout waiting for the stream to drain");
      end
      // counters settle one cycle after the last event
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_count("pkt_count", pkt_count, exp_pkt);
      check_count("tcp_count", tcp_count, exp_tcp);
      check_count("udp_count", udp_count, exp_udp);
      check_count("icmp_count", icmp_count, exp_icmp);
      check_count("sctp_count", sctp_count, exp_sctp);
      check_count("flow_valid pulses", 32'(flow_pulses), exp_tcp);
      if (exp_flow_q.size() != 0) begin
         stop_with_failure("expected TCP flows never appeared");
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

// ==== project.f ====
+incdir+.
sniff_pkg.sv
parse_event_if.sv
pkt_fifo.sv
hdr_parser.sv
proto_stats.sv
pkt_sniffer.sv
tb_pkt_sniffer.sv

// ==== Makefile ====
# Verilator build and run for the packet sniffer testbench

VERILATOR ?= verilator
TOP       ?= tb_pkt_sniffer
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then echo "simulation PASSED"; \
	else echo "simulation FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)
